/* common/dllp_settings.svh */
// dllp transmit settings for the update period and the advertised initial credits
`ifndef DLLP_SETTINGS_SVH
`define DLLP_SETTINGS_SVH

// update interval in clock cycles, short for simulation
`define DLLP_FC_PERIOD 64

// initial posted credits
`define DLLP_PH_INIT 32
`define DLLP_PD_INIT 256

// initial non-posted credits
`define DLLP_NPH_INIT 32
`define DLLP_NPD_INIT 64

// completions are infinite, so both fields advertise zero
`define DLLP_CPLH_INIT 0
`define DLLP_CPLD_INIT 0

`endif

/* common/dllp_pkg.sv */
// dllp transmit package, DLLP type codes, controller states and stream beat types
`default_nettype none

package dllp_pkg;

  // type byte of each DLLP on VC0
  typedef enum logic [7:0] {
    DLLP_ACK           = 8'h00,
    DLLP_NAK           = 8'h10,
    DLLP_UPDATE_FC_P   = 8'h80,
    DLLP_UPDATE_FC_NP  = 8'h90,
    DLLP_UPDATE_FC_CPL = 8'hA0
  } dllp_type_e;

  // one body state and one crc state per DLLP
  typedef enum logic [3:0] {
    IDLE,
    ACK_BODY,
    ACK_CRC,
    P_BODY,
    P_CRC,
    NP_BODY,
    NP_CRC,
    CPL_BODY,
    CPL_CRC,
    WAIT_LOW
  } fc_state_e;

  // consumed counts of one credit class
  typedef struct packed {
    logic [7:0]  hdr;
    logic [11:0] data;
  } fc_credits_t;

  // a single 32-bit stream beat
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  keep;
    logic        last;
  } dllp_beat_t;

endpackage

`default_nettype wire

/* source/dllp_tx_ctrl.sv */
// dllp transmit controller, orders the DLLPs, runs the update timer and the request handshake
`timescale 1ns/1ps
`default_nettype none
`include "dllp_settings.svh"

module dllp_tx_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 ack_req_i,
  input  logic                 nak_i,
  input  logic                 link_active_i,
  output logic                 ack_done_o,
  output dllp_pkg::dllp_type_e dllp_type_o,
  output logic                 crc_phase_o,
  output logic                 beat_valid_o,
  input  logic                 beat_ready_i
);
  import dllp_pkg::*;

  localparam int timer_w = $clog2(`DLLP_FC_PERIOD + 1);
  localparam logic [timer_w-1:0] timer_max = timer_w'(`DLLP_FC_PERIOD);

  fc_state_e          state_q;
  fc_state_e          state_d;
  logic [timer_w-1:0] timer_q;
  logic [timer_w-1:0] timer_d;
  logic               req_seq_q;
  logic               req_seq_d;
  logic               done_q;
  logic               done_d;
  logic               beat_xfer;

  assign beat_xfer  = beat_valid_o && beat_ready_i;
  assign ack_done_o = done_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      timer_q   <= '0;
      req_seq_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      timer_q   <= timer_d;
      req_seq_q <= req_seq_d;
      done_q    <= done_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    timer_d      = timer_q;
    req_seq_d    = req_seq_q;
    done_d       = 1'b0;
    beat_valid_o = 1'b1;
    crc_phase_o  = 1'b0;
    dllp_type_o  = DLLP_ACK;
    case (state_q)
      IDLE: begin
        beat_valid_o = 1'b0;
        // saturating update timer
        timer_d = (timer_q == timer_max) ? timer_q : timer_q + 1'b1;
        if (ack_req_i) begin
          state_d   = ACK_BODY;
          timer_d   = '0;
          req_seq_d = 1'b1;
        end else if ((timer_q == timer_max) && link_active_i) begin
          state_d   = P_BODY;
          timer_d   = '0;
          req_seq_d = 1'b0;
        end
      end
      ACK_BODY: begin
        dllp_type_o = nak_i ? DLLP_NAK : DLLP_ACK;
        if (beat_xfer) state_d = ACK_CRC;
      end
      ACK_CRC: begin
        dllp_type_o = nak_i ? DLLP_NAK : DLLP_ACK;
        crc_phase_o = 1'b1;
        if (beat_xfer) begin
          // a nak carries no credit updates
          state_d = nak_i ? WAIT_LOW : P_BODY;
          done_d  = nak_i;
        end
      end
      P_BODY: begin
        dllp_type_o = DLLP_UPDATE_FC_P;
        if (beat_xfer) state_d = P_CRC;
      end
      P_CRC: begin
        dllp_type_o = DLLP_UPDATE_FC_P;
        crc_phase_o = 1'b1;
        if (beat_xfer) state_d = NP_BODY;
      end
      NP_BODY: begin
        dllp_type_o = DLLP_UPDATE_FC_NP;
        if (beat_xfer) state_d = NP_CRC;
      end
      NP_CRC: begin
        dllp_type_o = DLLP_UPDATE_FC_NP;
        crc_phase_o = 1'b1;
        if (beat_xfer) state_d = CPL_BODY;
      end
      CPL_BODY: begin
        dllp_type_o = DLLP_UPDATE_FC_CPL;
        if (beat_xfer) state_d = CPL_CRC;
      end
      CPL_CRC: begin
        dllp_type_o = DLLP_UPDATE_FC_CPL;
        crc_phase_o = 1'b1;
        if (beat_xfer) begin
          // periodic sequences skip the handshake
          state_d = req_seq_q ? WAIT_LOW : IDLE;
          done_d  = req_seq_q;
        end
      end
      WAIT_LOW: begin
        beat_valid_o = 1'b0;
        // done is held until the requester drops its request
        if (ack_req_i) done_d = 1'b1;
        else state_d = IDLE;
      end
      default: begin
        beat_valid_o = 1'b0;
        state_d      = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/dllp_encode.sv */
// dllp body encoder, packs the Ack/Nak or UpdateFC fields into the 32-bit body word
`timescale 1ns/1ps
`default_nettype none
`include "dllp_settings.svh"

module dllp_encode (
  input  dllp_pkg::dllp_type_e  dllp_type_i,
  input  logic [11:0]           next_seq_i,
  input  dllp_pkg::fc_credits_t p_credits_i,
  input  dllp_pkg::fc_credits_t np_credits_i,
  output logic [31:0]           body_o
);
  import dllp_pkg::*;

  localparam fc_credits_t cpl_adv = '{hdr: 8'(`DLLP_CPLH_INIT), data: 12'(`DLLP_CPLD_INIT)};

  fc_credits_t p_adv;
  fc_credits_t np_adv;
  fc_credits_t fc_sel;
  logic [7:0]  byte1;
  logic [7:0]  byte2;
  logic [7:0]  byte3;

  // advertised limit is consumed plus initial, wrapping at the field width
  assign p_adv.hdr   = p_credits_i.hdr + 8'(`DLLP_PH_INIT);
  assign p_adv.data  = p_credits_i.data + 12'(`DLLP_PD_INIT);
  assign np_adv.hdr  = np_credits_i.hdr + 8'(`DLLP_NPH_INIT);
  assign np_adv.data = np_credits_i.data + 12'(`DLLP_NPD_INIT);

  always_comb begin
    case (dllp_type_i)
      DLLP_UPDATE_FC_P:  fc_sel = p_adv;
      DLLP_UPDATE_FC_NP: fc_sel = np_adv;
      default:           fc_sel = cpl_adv;
    endcase
    if ((dllp_type_i == DLLP_ACK) || (dllp_type_i == DLLP_NAK)) begin
      // ack/nak layout, sequence number in bytes 2 and 3
      byte1 = 8'h00;
      byte2 = {4'h0, next_seq_i[11:8]};
      byte3 = next_seq_i[7:0];
    end else begin
      byte1 = {2'b00, fc_sel.hdr[7:2]};
      byte2 = {fc_sel.hdr[1:0], 2'b00, fc_sel.data[11:8]};
      byte3 = fc_sel.data[7:0];
    end
  end

  // byte 0 lands in the low bits
  assign body_o = {byte3, byte2, byte1, dllp_type_i};

endmodule

`default_nettype wire

/* source/dllp_crc16.sv */
// dllp crc-16, serial crc over the body word unrolled into logic, formatted as the crc beat
`timescale 1ns/1ps
`default_nettype none

module dllp_crc16 (
  input  logic [31:0]          body_i,
  output dllp_pkg::dllp_beat_t crc_beat_o
);

  localparam logic [15:0] crc_poly = 16'h100B;
  localparam logic [15:0] crc_init = 16'hFFFF;

  logic [15:0] crc;
  logic [15:0] crc_inv;
  logic [15:0] crc_rev;

  // one step per body bit, bit 0 first
  always_comb begin : crc_loop
    logic fb;
    crc = crc_init;
    for (int i = 0; i < 32; i++) begin
      fb  = crc[15] ^ body_i[i];
      crc = {crc[14:0], 1'b0} ^ (fb ? crc_poly : 16'h0000);
    end
  end

  assign crc_inv = ~crc;

  // bit order flipped inside each byte
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      crc_rev[i]     = crc_inv[7-i];
      crc_rev[i+8]   = crc_inv[15-i];
    end
  end

  assign crc_beat_o.data = {16'h0000, crc_rev};
  assign crc_beat_o.keep = 4'b0011;
  assign crc_beat_o.last = 1'b1;

endmodule

`default_nettype wire

/* source/dllp_skid_buffer.sv */
// dllp stream skid buffer, two entries with a registered output and registered input ready
`timescale 1ns/1ps
`default_nettype none

module dllp_skid_buffer (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  dllp_pkg::dllp_beat_t s_beat_i,
  input  logic                 s_valid_i,
  output logic                 s_ready_o,
  output dllp_pkg::dllp_beat_t m_beat_o,
  output logic                 m_valid_o,
  input  logic                 m_ready_i
);
  import dllp_pkg::*;

  dllp_beat_t out_beat_q;
  logic       out_valid_q;
  dllp_beat_t skid_beat_q;
  logic       skid_valid_q;
  logic       out_free;

  // output register can load when empty or draining
  assign out_free = !out_valid_q || m_ready_i;

  // ready comes straight from a flop, low only with both entries full
  assign s_ready_o = !skid_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      // skid entry is older, so it goes first
      out_valid_q  <= skid_valid_q || s_valid_i;
      skid_valid_q <= 1'b0;
    end else if (s_valid_i && s_ready_o) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_free) begin
      out_beat_q <= skid_valid_q ? skid_beat_q : s_beat_i;
    end else if (s_ready_o) begin
      skid_beat_q <= s_beat_i;
    end
  end

  assign m_beat_o  = out_beat_q;
  assign m_valid_o = out_valid_q;

endmodule

`default_nettype wire

/* source/dllp_tx_top.sv */
// dllp transmit top, joins controller, encoder, crc and skid buffer onto one stream output
`timescale 1ns/1ps
`default_nettype none

module dllp_tx_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  ack_req_i,
  input  logic                  nak_i,
  input  logic [11:0]           next_seq_i,
  output logic                  ack_done_o,
  input  logic                  link_active_i,
  input  dllp_pkg::fc_credits_t p_credits_i,
  input  dllp_pkg::fc_credits_t np_credits_i,
  output logic [31:0]           m_tdata_o,
  output logic [3:0]            m_tkeep_o,
  output logic                  m_tvalid_o,
  output logic                  m_tlast_o,
  input  logic                  m_tready_i
);
  import dllp_pkg::*;

  dllp_type_e dllp_type;
  logic       crc_phase;
  logic       beat_valid;
  logic       beat_ready;
  logic [31:0] body;
  dllp_beat_t body_beat;
  dllp_beat_t crc_beat;
  dllp_beat_t in_beat;
  dllp_beat_t out_beat;

  dllp_tx_ctrl dllp_tx_ctrl_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .ack_req_i     (ack_req_i),
    .nak_i         (nak_i),
    .link_active_i (link_active_i),
    .ack_done_o    (ack_done_o),
    .dllp_type_o   (dllp_type),
    .crc_phase_o   (crc_phase),
    .beat_valid_o  (beat_valid),
    .beat_ready_i  (beat_ready)
  );

  dllp_encode dllp_encode_i (
    .dllp_type_i  (dllp_type),
    .next_seq_i   (next_seq_i),
    .p_credits_i  (p_credits_i),
    .np_credits_i (np_credits_i),
    .body_o       (body)
  );

  dllp_crc16 dllp_crc16_i (
    .body_i     (body),
    .crc_beat_o (crc_beat)
  );

  // full body word, never last
  assign body_beat = '{data: body, keep: 4'b1111, last: 1'b0};
  assign in_beat   = crc_phase ? crc_beat : body_beat;

  dllp_skid_buffer dllp_skid_buffer_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s_beat_i  (in_beat),
    .s_valid_i (beat_valid),
    .s_ready_o (beat_ready),
    .m_beat_o  (out_beat),
    .m_valid_o (m_tvalid_o),
    .m_ready_i (m_tready_i)
  );

  assign m_tdata_o = out_beat.data;
  assign m_tkeep_o = out_beat.keep;
  assign m_tlast_o = out_beat.last;

endmodule

`default_nettype wire

/* sim/dllp_tx_properties.sv */
// dllp transmit properties, output stall stability, last beat format and request handshake
`timescale 1ns/1ps
`default_nettype none

module dllp_tx_properties (
  input logic        clk_i,
  input logic        rst_i,
  input logic        ack_req_i,
  input logic        ack_done_i,
  input logic [31:0] m_tdata_i,
  input logic [3:0]  m_tkeep_i,
  input logic        m_tvalid_i,
  input logic        m_tlast_i,
  input logic        m_tready_i
);

  // a stalled beat holds until it transfers
  stall_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    m_tvalid_i && !m_tready_i |=> m_tvalid_i && $stable({m_tdata_i, m_tkeep_i, m_tlast_i}))
    else $error("stalled output beat changed before its transfer");

  // crc beat carries two bytes
  last_keep: assert property (@(posedge clk_i) disable iff (rst_i)
    m_tvalid_i && m_tlast_i |-> m_tkeep_i == 4'b0011)
    else $error("last beat without keep 0011");

  done_falls_late: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(ack_done_i) |-> $past(!ack_req_i))
    else $error("ack_done fell while the request was still high");

  reset_quiet: assert property (@(posedge clk_i) rst_i |=> !m_tvalid_i)
    else $error("output valid high in the cycle after reset");

endmodule

bind dllp_tx_top dllp_tx_properties dllp_tx_properties_i (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .ack_req_i  (ack_req_i),
  .ack_done_i (ack_done_o),
  .m_tdata_i  (m_tdata_o),
  .m_tkeep_i  (m_tkeep_o),
  .m_tvalid_i (m_tvalid_o),
  .m_tlast_i  (m_tlast_o),
  .m_tready_i (m_tready_i)
);

`default_nettype wire

/* sim/dllp_tx_tb.sv */
// dllp transmit testbench that checks random requests and credits against a reference model
`timescale 1ns/1ps
`default_nettype none
`include "dllp_settings.svh"

module dllp_tx_tb;
  import dllp_pkg::*;

  // 40 sequences of 8 beats with up to 4 stall cycles each and one update period per sequence
  localparam int timeout_cycles = 40 * (8 * 4 + `DLLP_FC_PERIOD) + 200;

  logic        clk_i;
  logic        rst_i;
  logic        ack_req_i;
  logic        nak_i;
  logic [11:0] next_seq_i;
  logic        ack_done_o;
  logic        link_active_i;
  fc_credits_t p_credits_i;
  fc_credits_t np_credits_i;
  logic [31:0] m_tdata_o;
  logic [3:0]  m_tkeep_o;
  logic        m_tvalid_o;
  logic        m_tlast_o;
  logic        m_tready_i;

  logic [15:0] lfsr;
  logic [31:0] ready_bits;
  logic        random_ready;
  int          cycles;
  string       test_name;
  dllp_beat_t  exp_q[$];

  dllp_tx_top dllp_tx_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
  endtask

  task automatic end_failed(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp)
      else end_failed($sformatf("FAIL %s expected %b actual %b", name, exp, act));
  endtask

  // bit-serial crc-16 over poly 100B with body bit 0 first
  function automatic logic [15:0] dllp_crc(input logic [31:0] body);
    logic [15:0] c;
    logic [15:0] r;
    c = 16'hFFFF;
    for (int i = 0; i < 32; i++) begin
      if (c[15] ^ body[i]) c = {c[14:0], 1'b0} ^ 16'h100B;
      else c = {c[14:0], 1'b0};
    end
    c = ~c;
    for (int i = 0; i < 16; i++) r[i] = c[(i & 8) + 7 - (i & 7)];
    return r;
  endfunction

  task automatic push_dllp(input logic [7:0] t, input logic [7:0] b1, input logic [7:0] b2,
                           input logic [7:0] b3);
    logic [31:0] body;
    body = {b3, b2, b1, t};
    exp_q.push_back('{data: body, keep: 4'b1111, last: 1'b0});
    exp_q.push_back('{data: {16'h0000, dllp_crc(body)}, keep: 4'b0011, last: 1'b1});
  endtask

  task automatic push_fc(input logic [7:0] t, input logic [7:0] hdr, input logic [11:0] data);
    push_dllp(t, {2'b00, hdr[7:2]}, {hdr[1:0], 2'b00, data[11:8]}, data[7:0]);
  endtask

  // consumed count plus initial credit, modulo 256 for headers and 4096 for data
  task automatic push_updates();
    int ph;
    int pd;
    int nph;
    int npd;
    ph  = (p_credits_i.hdr + `DLLP_PH_INIT) % 256;
    pd  = (p_credits_i.data + `DLLP_PD_INIT) % 4096;
    nph = (np_credits_i.hdr + `DLLP_NPH_INIT) % 256;
    npd = (np_credits_i.data + `DLLP_NPD_INIT) % 4096;
    push_fc(8'h80, ph[7:0], pd[11:0]);
    push_fc(8'h90, nph[7:0], npd[11:0]);
    push_fc(8'hA0, 8'h00, 12'h000);
  endtask

  task automatic new_credits();
    logic [31:0] r;
    draw_bits(20, r);
    p_credits_i <= r[19:0];
    draw_bits(20, r);
    np_credits_i <= r[19:0];
    @(posedge clk_i);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  task automatic run_request(input logic nak);
    logic [31:0] r;
    draw_bits(12, r);
    ack_req_i  <= 1'b1;
    nak_i      <= nak;
    next_seq_i <= r[11:0];
    push_dllp(nak ? 8'h10 : 8'h00, 8'h00, {4'h0, r[11:8]}, r[7:0]);
    if (!nak) push_updates();
    do @(posedge clk_i); while (ack_done_o !== 1'b1);
    // done must hold while the request is still up
    repeat (2) begin
      @(posedge clk_i);
      check_bit({test_name, " ack_done_o held"}, 1'b1, ack_done_o);
    end
    ack_req_i <= 1'b0;
    do @(posedge clk_i); while (ack_done_o !== 1'b0);
    wait_drain();
  endtask

  // ready drawn on the falling edge and driven on the rising edge
  always @(negedge clk_i) begin
    if (random_ready) draw_bits(1, ready_bits);
  end

  always @(posedge clk_i) begin
    m_tready_i <= random_ready ? ready_bits[0] : 1'b1;
  end

  always @(posedge clk_i) begin : monitor
    dllp_beat_t got;
    dllp_beat_t exp;
    if (!rst_i && m_tvalid_o) begin
      assert (exp_q.size() != 0)
        else end_failed($sformatf("%s: beat %h appeared with none expected", test_name,
                                  m_tdata_o));
      if (m_tready_i) begin
        got = '{data: m_tdata_o, keep: m_tkeep_o, last: m_tlast_o};
        exp = exp_q.pop_front();
        assert (got === exp)
          else end_failed($sformatf("FAIL %s expected %h actual %h", test_name, exp, got));
      end
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles)
      end_failed($sformatf("timeout after %0d cycles in test %s", cycles, test_name));
  end

  initial begin
    logic [31:0] r;
    lfsr          = 16'd33317;
    ready_bits    = '1;
    random_ready  <= 1'b0;
    cycles        = 0;
    test_name     = "reset";
    rst_i         <= 1'b1;
    ack_req_i     <= 1'b0;
    nak_i         <= 1'b0;
    next_seq_i    <= '0;
    link_active_i <= 1'b0;
    p_credits_i   <= '0;
    np_credits_i  <= '0;
    m_tready_i    <= 1'b1;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_bit("reset m_tvalid_o", 1'b0, m_tvalid_o);
    check_bit("reset ack_done_o", 1'b0, ack_done_o);
    // the monitor flags any beat on a quiet link
    repeat (3 * `DLLP_FC_PERIOD) @(posedge clk_i);

    test_name = "ack";
    new_credits();
    run_request(1'b0);
    test_name = "nak";
    run_request(1'b1);

    test_name = "periodic";
    new_credits();
    repeat (4) push_updates();
    link_active_i <= 1'b1;
    wait_drain();
    link_active_i <= 1'b0;
    test_name = "link down";
    repeat (3 * `DLLP_FC_PERIOD) @(posedge clk_i);

    test_name = "back-pressure";
    random_ready <= 1'b1;
    repeat (24) begin
      new_credits();
      draw_bits(1, r);
      run_request(r[0]);
    end
    random_ready <= 1'b0;
    repeat (4) @(posedge clk_i);

    if (exp_q.size() != 0) begin
      end_failed($sformatf("%0d expected beats never appeared", exp_q.size()));
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dllp_tx_top.f */
+incdir+common
common/dllp_pkg.sv
source/dllp_tx_ctrl.sv
source/dllp_encode.sv
source/dllp_crc16.sv
source/dllp_skid_buffer.sv
source/dllp_tx_top.sv
sim/dllp_tx_properties.sv
sim/dllp_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the dllp transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dllp_tx_tb \
  -f dllp_tx_top.f -o dllp_tx_sim

sim_status=0
./obj_dir/dllp_tx_sim > sim.log 2>&1 || sim_status=$?
cat sim.log

# an assertion stop ends the run without the testbench's own message
if grep -q "TESTBENCH FAILED" sim.log || [ "$sim_status" -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
